//--- thumb_ctrl_stim.txt
# name valid instr valid_o stall reg_wr mem_rd mem_wr wb_mem st_sel upd_flag alu src_a ctrl_reg offset
# single bits in binary; instr, alu, ctrl_reg and offset in hex; one line per clock cycle
idle_start   0 ffff 0 0 0 0 0 0 0 0 0 0 0 0
dp_and       1 4011 1 0 1 0 0 0 0 1 2 0 0 0
add_sub_reg  1 1a8a 1 0 1 0 0 0 0 1 1 0 0 0
dp_cmp       1 4288 1 0 0 0 0 0 0 1 1 0 0 0
cmp_imm      1 2905 1 0 0 0 0 0 0 1 1 0 0 0
mov_imm      1 2342 1 0 1 0 0 0 0 1 0 1 0 0
dp_neg       1 4253 1 0 1 0 0 0 0 1 1 1 0 0
ldr_imm      1 6888 1 0 1 1 0 1 0 0 0 0 0 0
str_imm      1 6088 1 0 0 0 1 1 0 0 0 0 0 0
str_reg      1 5088 1 0 0 0 1 1 1 0 0 0 0 0
ldr_reg      1 5888 1 0 1 1 0 1 0 0 0 0 0 0
ldrsb_reg    1 5688 1 0 1 1 0 1 0 0 0 0 0 0
push_b0      1 b452 1 1 0 0 1 0 0 0 1 0 1 c
push_b1      1 b452 1 1 0 0 1 0 0 0 1 0 4 8
push_b2      1 b452 1 1 0 0 1 0 0 0 1 0 6 4
push_fin     1 b452 1 0 1 0 0 0 0 0 1 0 d c
ldm_b0       1 ca09 1 1 1 0 0 1 0 0 0 0 3 4
ldm_b1       1 ca09 1 1 1 0 0 1 0 0 0 0 0 0
ldm_fin      1 ca09 1 0 1 0 0 0 0 0 0 0 2 8
ldm_base_b0  1 ca24 1 1 1 0 0 1 0 0 0 0 5 4
ldm_base_b1  1 ca24 1 1 1 0 0 1 0 0 0 0 2 0
ldm_base_fin 1 ca24 1 0 0 0 0 0 0 0 0 0 2 8
stm_b0       1 c583 1 1 0 0 1 0 0 0 0 0 0 0
stm_b1       1 c583 1 1 0 0 1 0 0 0 0 0 1 4
stm_b2       1 c583 1 1 0 0 1 0 0 0 0 0 7 8
stm_fin      1 c583 1 0 1 0 0 0 0 0 0 0 5 c
pop_b0       1 bd0c 1 1 1 0 0 1 0 0 0 0 2 0
pop_b1       1 bd0c 1 1 1 0 0 1 0 0 0 0 3 4
pop_fin      1 bd0c 1 0 1 0 0 0 0 0 0 0 d 8
bad_undef    1 ffff 0 0 0 0 0 0 0 0 0 0 0 0
bad_bx       1 4700 0 0 0 0 0 0 0 0 0 0 0 0
empty_push   1 b400 0 0 0 0 0 0 0 0 0 0 0 0
empty_ldm    1 c900 0 0 0 0 0 0 0 0 0 0 0 0
drop_b0      1 b452 1 1 0 0 1 0 0 0 1 0 1 c
drop_b1      1 b452 1 1 0 0 1 0 0 0 1 0 4 8
drop_bubble  0 ffff 0 0 0 0 0 0 0 0 0 0 0 0
drop_re_b0   1 b452 1 1 0 0 1 0 0 0 1 0 1 c
drop_re_b1   1 b452 1 1 0 0 1 0 0 0 1 0 4 8
drop_re_b2   1 b452 1 1 0 0 1 0 0 0 1 0 6 4
drop_re_fin  1 b452 1 0 1 0 0 0 0 0 1 0 d c
idle_end     0 ffff 0 0 0 0 0 0 0 0 0 0 0 0

//--- files.f
+incdir+.
thumb_ctrl_pkg.sv
thumb_op_decoder.sv
reglist_sequencer.sv
ctrl_merge.sv
thumb_ctrl_top.sv
tb_thumb_ctrl.sv

//--- Makefile
TOP_TB  := tb_thumb_ctrl
TOP_RTL := thumb_ctrl_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP_RTL) -f files.f

# the run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP_TB) -f files.f -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; cat sim.log
	grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_thumb_ctrl.sv
`timescale 1ns/1ps
`include "thumb_ctrl_params.svh"

module tb_thumb_ctrl import thumb_ctrl_pkg::*; ();

    localparam int HALF_PERIOD  = 10;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;

    // decodes as an invalid encoding, so the unit stays quiet while idle
    localparam logic [`INSTR_W-1:0] IDLE_INSTR = 16'hffff;

    logic                   clk_i;
    logic                   reset_i;
    logic                   valid_i;
    logic [`INSTR_W-1:0]    instr_i;

    logic                   valid_o;
    logic                   stall_o;
    logic                   update_flag_o;
    logic                   reg_write_o;
    logic                   mem_read_o;
    logic                   mem_write_o;
    logic                   wb_from_mem_o;
    logic                   store_data_sel_o;
    logic [3:0]             alu_op_o;
    logic                   src_a_o;
    logic [1:0]             src_b_o;
    logic                   read_addr_sel_o;
    logic                   dest_addr_sel_o;
    logic [`REG_ADDR_W-1:0] ctrl_reg_addr_o;
    logic [`WORD_W-1:0]     offset_imm_o;

    // one entry per cycle of the stim file
    string                  vec_name[$];
    logic                   vec_valid[$];
    logic [`INSTR_W-1:0]    vec_instr[$];
    logic [8:0]             vec_flags[$];
    logic [3:0]             vec_alu[$];
    logic [`REG_ADDR_W-1:0] vec_ctrl_reg[$];
    logic [`WORD_W-1:0]     vec_offset[$];

    int                     num_vec;
    int                     error_count;
    string                  cur_name;

    thumb_ctrl_top thumb_ctrl_top_i (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .valid_i          (valid_i),
        .instr_i          (instr_i),
        .valid_o          (valid_o),
        .stall_o          (stall_o),
        .update_flag_o    (update_flag_o),
        .reg_write_o      (reg_write_o),
        .mem_read_o       (mem_read_o),
        .mem_write_o      (mem_write_o),
        .wb_from_mem_o    (wb_from_mem_o),
        .store_data_sel_o (store_data_sel_o),
        .alu_op_o         (alu_op_o),
        .src_a_o          (src_a_o),
        .src_b_o          (src_b_o),
        .read_addr_sel_o  (read_addr_sel_o),
        .dest_addr_sel_o  (dest_addr_sel_o),
        .ctrl_reg_addr_o  (ctrl_reg_addr_o),
        .offset_imm_o     (offset_imm_o)
    );

    always #HALF_PERIOD clk_i = ~clk_i;

    task automatic parse_line(input string line);
        string               t_name;
        logic                t_valid;
        logic [`INSTR_W-1:0] t_instr;
        logic                t_vld;
        logic                t_stall;
        logic                t_rw;
        logic                t_mr;
        logic                t_mw;
        logic                t_wbm;
        logic                t_sds;
        logic                t_uf;
        logic [3:0]          t_alu;
        logic                t_srca;
        logic [`REG_ADDR_W-1:0] t_ctrl;
        logic [`WORD_W-1:0]  t_off;
        int                  n;
        if (line.len() < 2 || line.getc(0) == "#") begin
            return;
        end
        n = $sscanf(line, "%s %b %h %b %b %b %b %b %b %b %b %h %b %h %h",
                    t_name, t_valid, t_instr, t_vld, t_stall, t_rw, t_mr, t_mw,
                    t_wbm, t_sds, t_uf, t_alu, t_srca, t_ctrl, t_off);
        if (n != 15) begin
            $display("stim line has %0d of 15 fields and was skipped: %s", n, line);
            error_count++;
        end else begin
            vec_name.push_back(t_name);
            vec_valid.push_back(t_valid);
            vec_instr.push_back(t_instr);
            vec_flags.push_back({t_vld, t_stall, t_rw, t_mr, t_mw, t_wbm, t_sds, t_uf, t_srca});
            vec_alu.push_back(t_alu);
            vec_ctrl_reg.push_back(t_ctrl);
            vec_offset.push_back(t_off);
        end
    endtask

    task automatic load_vectors();
        int    fd;
        string line;
        fd = $fopen("thumb_ctrl_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open thumb_ctrl_stim.txt for reading");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    parse_line(line);
                end
            end
            $fclose(fd);
        end
        num_vec = vec_name.size();
        if (num_vec == 0) begin
            $display("no test vectors were read from the stim file");
            error_count++;
        end
    endtask

    // PUSH, POP, STM and LDM with at least one listed register
    function automatic logic is_list_instr(input logic [`INSTR_W-1:0] instr);
        logic is_push_pop;
        logic is_stm_ldm;
        is_push_pop = (instr[15:9] == 7'b1011010) || (instr[15:9] == 7'b1011110);
        is_stm_ldm  = (instr[15:11] == 5'b11000) || (instr[15:11] == 5'b11001);
        return (is_push_pop || is_stm_ldm) && (instr[7:0] != 8'h00);
    endfunction

    task automatic check_field(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %0s %0s: expected %0h, actual %0h",
                     cur_name, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_vector(input int idx);
        logic [8:0] flags;
        logic       list_instr;
        logic       exp_read_sel;
        logic       exp_dest_sel;
        flags      = vec_flags[idx];
        cur_name   = vec_name[idx];
        list_instr = is_list_instr(vec_instr[idx]);
        check_field("valid_o", 32'(flags[8]), 32'(valid_o));
        check_field("stall_o", 32'(flags[7]), 32'(stall_o));
        check_field("reg_write_o", 32'(flags[6]), 32'(reg_write_o));
        check_field("mem_read_o", 32'(flags[5]), 32'(mem_read_o));
        check_field("mem_write_o", 32'(flags[4]), 32'(mem_write_o));
        check_field("wb_from_mem_o", 32'(flags[3]), 32'(wb_from_mem_o));
        check_field("store_data_sel_o", 32'(flags[2]), 32'(store_data_sel_o));
        check_field("update_flag_o", 32'(flags[1]), 32'(update_flag_o));
        check_field("src_a_o", 32'(flags[0]), 32'(src_a_o));
        check_field("alu_op_o", 32'(vec_alu[idx]), 32'(alu_op_o));
        check_field("ctrl_reg_addr_o", 32'(vec_ctrl_reg[idx]), 32'(ctrl_reg_addr_o));
        check_field("offset_imm_o", vec_offset[idx], offset_imm_o);

        // every beat of a list instruction adds or subtracts the offset immediate
        if (list_instr) begin
            check_field("src_b_o", 32'(SRC_B_OFFSET), 32'(src_b_o));
        end

        // only the store beats of PUSH and STM read the register chosen by the sequencer
        exp_read_sel = (list_instr && flags[7] && flags[4]) ? ADDR_FROM_CTRL : ADDR_FROM_INSTR;
        check_field("read_addr_sel_o", 32'(exp_read_sel), 32'(read_addr_sel_o));

        if (flags[6]) begin
            exp_dest_sel = list_instr ? ADDR_FROM_CTRL : ADDR_FROM_INSTR;
            check_field("dest_addr_sel_o", 32'(exp_dest_sel), 32'(dest_addr_sel_o));
        end
    endtask

    initial begin
        clk_i       = 1'b0;
        reset_i     = 1'b1;
        valid_i     = 1'b0;
        instr_i     = IDLE_INSTR;
        error_count = 0;
        num_vec     = 0;
        load_vectors();

        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_i <= 1'b0;

        // each line is applied at a rising edge and checked at the falling edge
        // while valid_i is low the fetch stage keeps its instruction on instr_i
        // and the outputs carry no instruction, so nothing is compared
        for (int i = 0; i < num_vec; i++) begin
            @(posedge clk_i);
            valid_i <= vec_valid[i];
            if (vec_valid[i]) begin
                instr_i <= vec_instr[i];
            end
            @(negedge clk_i);
            if (vec_valid[i]) begin
                check_vector(i);
            end
        end

        @(posedge clk_i);
        $display("run complete: %0d vectors, %0d errors", num_vec, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // the vector count is known once the file has been read at time zero
    initial begin
        #1;
        #((num_vec + 20) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", num_vec + 20);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- thumb_ctrl_top.sv
`timescale 1ns/1ps

module thumb_ctrl_top import thumb_ctrl_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      valid_i,
    input  instr_t    instr_i,
    output logic      valid_o,
    output logic      stall_o,
    output logic      update_flag_o,
    output logic      reg_write_o,
    output logic      mem_read_o,
    output logic      mem_write_o,
    output logic      wb_from_mem_o,
    output logic      store_data_sel_o,
    output alu_op_e   alu_op_o,
    output src_a_e    src_a_o,
    output src_b_e    src_b_o,
    output addr_sel_e read_addr_sel_o,
    output addr_sel_e dest_addr_sel_o,
    output reg_addr_t ctrl_reg_addr_o,
    output word_t     offset_imm_o
);

    instr_class_e cls;
    reg_list_t    reg_list;
    reg_addr_t    base_reg;
    alu_op_e      dec_alu_op;
    src_a_e       dec_src_a;
    src_b_e       dec_src_b;
    logic         dec_update_flag;
    logic         dec_reg_write;
    logic         dec_mem_read;
    logic         dec_mem_write;
    logic         dec_wb_from_mem;
    logic         dec_store_data_sel;

    logic         seq_active;
    reg_addr_t    cur_reg;
    beat_t        beat;
    beat_t        list_count;
    logic         base_in_list;

    thumb_op_decoder u_op_decoder (
        .instr_i          (instr_i),
        .cls_o            (cls),
        .reg_list_o       (reg_list),
        .base_reg_o       (base_reg),
        .alu_op_o         (dec_alu_op),
        .src_a_o          (dec_src_a),
        .src_b_o          (dec_src_b),
        .update_flag_o    (dec_update_flag),
        .reg_write_o      (dec_reg_write),
        .mem_read_o       (dec_mem_read),
        .mem_write_o      (dec_mem_write),
        .wb_from_mem_o    (dec_wb_from_mem),
        .store_data_sel_o (dec_store_data_sel)
    );

    reglist_sequencer u_reglist_sequencer (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .valid_i        (valid_i),
        .cls_i          (cls),
        .reg_list_i     (reg_list),
        .base_reg_i     (base_reg),
        .seq_active_o   (seq_active),
        .cur_reg_o      (cur_reg),
        .beat_o         (beat),
        .list_count_o   (list_count),
        .base_in_list_o (base_in_list)
    );

    ctrl_merge u_ctrl_merge (
        .cls_i            (cls),
        .alu_op_i         (dec_alu_op),
        .src_a_i          (dec_src_a),
        .src_b_i          (dec_src_b),
        .update_flag_i    (dec_update_flag),
        .reg_write_i      (dec_reg_write),
        .mem_read_i       (dec_mem_read),
        .mem_write_i      (dec_mem_write),
        .wb_from_mem_i    (dec_wb_from_mem),
        .store_data_sel_i (dec_store_data_sel),
        .seq_active_i     (seq_active),
        .cur_reg_i        (cur_reg),
        .beat_i           (beat),
        .list_count_i     (list_count),
        .base_in_list_i   (base_in_list),
        .base_reg_i       (base_reg),
        .valid_o          (valid_o),
        .stall_o          (stall_o),
        .update_flag_o    (update_flag_o),
        .reg_write_o      (reg_write_o),
        .mem_read_o       (mem_read_o),
        .mem_write_o      (mem_write_o),
        .wb_from_mem_o    (wb_from_mem_o),
        .store_data_sel_o (store_data_sel_o),
        .alu_op_o         (alu_op_o),
        .src_a_o          (src_a_o),
        .src_b_o          (src_b_o),
        .read_addr_sel_o  (read_addr_sel_o),
        .dest_addr_sel_o  (dest_addr_sel_o),
        .ctrl_reg_addr_o  (ctrl_reg_addr_o),
        .offset_imm_o     (offset_imm_o)
    );

endmodule

//--- ctrl_merge.sv
`timescale 1ns/1ps
`include "thumb_ctrl_params.svh"

module ctrl_merge import thumb_ctrl_pkg::*; (
    input  instr_class_e cls_i,
    input  alu_op_e      alu_op_i,
    input  src_a_e       src_a_i,
    input  src_b_e       src_b_i,
    input  logic         update_flag_i,
    input  logic         reg_write_i,
    input  logic         mem_read_i,
    input  logic         mem_write_i,
    input  logic         wb_from_mem_i,
    input  logic         store_data_sel_i,
    input  logic         seq_active_i,
    input  reg_addr_t    cur_reg_i,
    input  beat_t        beat_i,
    input  beat_t        list_count_i,
    input  logic         base_in_list_i,
    input  reg_addr_t    base_reg_i,
    output logic         valid_o,
    output logic         stall_o,
    output logic         update_flag_o,
    output logic         reg_write_o,
    output logic         mem_read_o,
    output logic         mem_write_o,
    output logic         wb_from_mem_o,
    output logic         store_data_sel_o,
    output alu_op_e      alu_op_o,
    output src_a_e       src_a_o,
    output src_b_e       src_b_o,
    output addr_sel_e    read_addr_sel_o,
    output addr_sel_e    dest_addr_sel_o,
    output reg_addr_t    ctrl_reg_addr_o,
    output word_t        offset_imm_o
);

    word_t beat_off;
    word_t list_off;

    // 4k for the current beat and 4N for the whole list
    assign beat_off = word_t'(beat_i) << 2;
    assign list_off = word_t'(list_count_i) << 2;

    always_comb begin
        valid_o          = 1'b0;
        stall_o          = 1'b0;
        update_flag_o    = 1'b0;
        reg_write_o      = 1'b0;
        mem_read_o       = 1'b0;
        mem_write_o      = 1'b0;
        wb_from_mem_o    = 1'b0;
        store_data_sel_o = 1'b0;
        alu_op_o         = ADD;
        src_a_o          = SRC_A_REG;
        src_b_o          = SRC_B_REG;
        read_addr_sel_o  = ADDR_FROM_INSTR;
        dest_addr_sel_o  = ADDR_FROM_INSTR;
        ctrl_reg_addr_o  = '0;
        offset_imm_o     = '0;

        case (cls_i)
            CLS_SINGLE: begin
                valid_o          = 1'b1;
                update_flag_o    = update_flag_i;
                reg_write_o      = reg_write_i;
                mem_read_o       = mem_read_i;
                mem_write_o      = mem_write_i;
                wb_from_mem_o    = wb_from_mem_i;
                store_data_sel_o = store_data_sel_i;
                alu_op_o         = alu_op_i;
                src_a_o          = src_a_i;
                src_b_o          = src_b_i;
            end
            CLS_PUSH, CLS_POP, CLS_STM, CLS_LDM: begin
                valid_o = 1'b1;
                stall_o = seq_active_i;
                src_b_o = SRC_B_OFFSET;
                if (seq_active_i) begin
                    ctrl_reg_addr_o = cur_reg_i;
                    case (cls_i)
                        CLS_PUSH: begin
                            // addresses run from SP-4N upward
                            alu_op_o        = SUB;
                            mem_write_o     = 1'b1;
                            read_addr_sel_o = ADDR_FROM_CTRL;
                            offset_imm_o    = list_off - beat_off;
                        end
                        CLS_STM: begin
                            mem_write_o     = 1'b1;
                            read_addr_sel_o = ADDR_FROM_CTRL;
                            offset_imm_o    = beat_off;
                        end
                        CLS_POP: begin
                            reg_write_o     = 1'b1;
                            wb_from_mem_o   = 1'b1;
                            dest_addr_sel_o = ADDR_FROM_CTRL;
                            offset_imm_o    = beat_off;
                        end
                        default: begin
                            // LDM walks down from base+4(N-1) since it sends the highest first
                            reg_write_o     = 1'b1;
                            wb_from_mem_o   = 1'b1;
                            dest_addr_sel_o = ADDR_FROM_CTRL;
                            offset_imm_o    = list_off - word_t'(4) - beat_off;
                        end
                    endcase
                end else begin
                    // final beat updates SP or the base by 4N, which also
                    // covers the load-use slot of the last loaded register
                    reg_write_o     = 1'b1;
                    dest_addr_sel_o = ADDR_FROM_CTRL;
                    offset_imm_o    = list_off;
                    ctrl_reg_addr_o = base_reg_i;
                    case (cls_i)
                        CLS_PUSH: begin
                            alu_op_o        = SUB;
                            ctrl_reg_addr_o = reg_addr_t'(`SP_REG_NUM);
                        end
                        CLS_POP: begin
                            ctrl_reg_addr_o = reg_addr_t'(`SP_REG_NUM);
                        end
                        CLS_LDM: begin
                            // a loaded base keeps its loaded value
                            reg_write_o = !base_in_list_i;
                        end
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase
    end

endmodule

//--- reglist_sequencer.sv
`timescale 1ns/1ps
`include "thumb_ctrl_params.svh"

module reglist_sequencer import thumb_ctrl_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,
    input  logic         valid_i,
    input  instr_class_e cls_i,
    input  reg_list_t    reg_list_i,
    input  reg_addr_t    base_reg_i,
    output logic         seq_active_o,
    output reg_addr_t    cur_reg_o,
    output beat_t        beat_o,
    output beat_t        list_count_o,
    output logic         base_in_list_o
);

    reg_list_t remain_q;
    beat_t     beat_q;
    logic      base_in_list_q;

    reg_list_t pending;
    reg_list_t pick_onehot;
    reg_addr_t cur_reg;
    logic      is_multi;
    logic      is_ldm;

    assign is_multi = (cls_i == CLS_PUSH) || (cls_i == CLS_POP) ||
                      (cls_i == CLS_STM) || (cls_i == CLS_LDM);
    assign is_ldm   = (cls_i == CLS_LDM);

    // listed registers that have not been sent yet
    assign pending      = reg_list_i & remain_q;
    assign seq_active_o = is_multi && (pending != '0);

    // the last hit wins, so the scan order sets the priority
    always_comb begin
        int j;
        cur_reg = '0;
        for (int i = 0; i < `REG_LIST_W; i++) begin
            j = is_ldm ? i : `REG_LIST_W - 1 - i;
            if (pending[j]) begin
                cur_reg = reg_addr_t'(j);
            end
        end
    end

    assign pick_onehot = reg_list_t'(1) << cur_reg;

    always_comb begin
        list_count_o = '0;
        for (int i = 0; i < `REG_LIST_W; i++) begin
            list_count_o = list_count_o + beat_t'(reg_list_i[i]);
        end
    end

    // state only moves while registers remain, so the final beat clears it
    always_ff @(posedge clk_i) begin
        if (reset_i || !valid_i || !seq_active_o) begin
            remain_q       <= '1;
            beat_q         <= '0;
            base_in_list_q <= 1'b0;
        end else begin
            remain_q <= remain_q & ~pick_onehot;
            beat_q   <= beat_q + beat_t'(1);
            if (cur_reg == base_reg_i) begin
                base_in_list_q <= 1'b1;
            end
        end
    end

    assign cur_reg_o      = cur_reg;
    assign beat_o         = beat_q;
    assign base_in_list_o = base_in_list_q;

endmodule

//--- thumb_op_decoder.sv
`timescale 1ns/1ps

module thumb_op_decoder import thumb_ctrl_pkg::*; (
    input  instr_t       instr_i,
    output instr_class_e cls_o,
    output reg_list_t    reg_list_o,
    output reg_addr_t    base_reg_o,
    output alu_op_e      alu_op_o,
    output src_a_e       src_a_o,
    output src_b_e       src_b_o,
    output logic         update_flag_o,
    output logic         reg_write_o,
    output logic         mem_read_o,
    output logic         mem_write_o,
    output logic         wb_from_mem_o,
    output logic         store_data_sel_o
);

    // list and base sit in the same bits for every multi-register form
    assign reg_list_o = instr_i[7:0];
    assign base_reg_o = {1'b0, instr_i[10:8]};

    always_comb begin
        cls_o            = CLS_INVALID;
        alu_op_o         = ADD;
        src_a_o          = SRC_A_REG;
        src_b_o          = SRC_B_REG;
        update_flag_o    = 1'b0;
        reg_write_o      = 1'b0;
        mem_read_o       = 1'b0;
        mem_write_o      = 1'b0;
        wb_from_mem_o    = 1'b0;
        store_data_sel_o = 1'b0;

        casez (instr_i[15:11])
            5'b00???: begin
                cls_o         = CLS_SINGLE;
                update_flag_o = 1'b1;
                reg_write_o   = 1'b1;
                case (instr_i[13:11])
                    3'b000: begin
                        alu_op_o = LSL;
                        src_b_o  = SRC_B_IMM;
                    end
                    3'b001: begin
                        alu_op_o = LSR;
                        src_b_o  = SRC_B_IMM;
                    end
                    3'b010: begin
                        alu_op_o = ASR;
                        src_b_o  = SRC_B_IMM;
                    end
                    3'b011: begin
                        // bit 10 picks the 3-bit immediate, bit 9 picks subtract
                        alu_op_o = instr_i[9] ? SUB : ADD;
                        src_b_o  = instr_i[10] ? SRC_B_IMM : SRC_B_REG;
                    end
                    3'b100: begin
                        // move immediate is 0 + imm8
                        src_a_o = SRC_A_ZERO;
                        src_b_o = SRC_B_IMM;
                    end
                    3'b101: begin
                        alu_op_o    = SUB;
                        src_b_o     = SRC_B_IMM;
                        reg_write_o = 1'b0;
                    end
                    3'b110: begin
                        src_b_o = SRC_B_IMM;
                    end
                    default: begin
                        alu_op_o = SUB;
                        src_b_o  = SRC_B_IMM;
                    end
                endcase
            end
            5'b01000: begin
                // 010001 is the special-register group, not handled here
                if (!instr_i[10]) begin
                    cls_o         = CLS_SINGLE;
                    update_flag_o = 1'b1;
                    reg_write_o   = 1'b1;
                    case (instr_i[9:6])
                        4'b0000: alu_op_o = AND;
                        4'b0001: alu_op_o = XOR;
                        4'b0010: alu_op_o = LSL;
                        4'b0011: alu_op_o = LSR;
                        4'b0100: alu_op_o = ASR;
                        4'b0101: alu_op_o = ADC;
                        4'b0110: alu_op_o = SBC;
                        4'b0111: alu_op_o = ROR;
                        4'b1000: begin
                            // test only sets flags
                            alu_op_o    = AND;
                            reg_write_o = 1'b0;
                        end
                        4'b1001: begin
                            // reverse subtract from zero
                            alu_op_o = SUB;
                            src_a_o  = SRC_A_ZERO;
                        end
                        4'b1010: begin
                            alu_op_o    = SUB;
                            reg_write_o = 1'b0;
                        end
                        4'b1011: begin
                            alu_op_o    = ADD;
                            reg_write_o = 1'b0;
                        end
                        4'b1100: alu_op_o = OR;
                        4'b1101: alu_op_o = MUL;
                        4'b1110: alu_op_o = BIC;
                        default: alu_op_o = NOT;
                    endcase
                end
            end
            5'b0101?: begin
                cls_o         = CLS_SINGLE;
                wb_from_mem_o = 1'b1;
                if (instr_i[11] || (instr_i[10:9] == 2'b11)) begin
                    mem_read_o  = 1'b1;
                    reg_write_o = 1'b1;
                end else begin
                    // store data comes from the third register field
                    mem_write_o      = 1'b1;
                    store_data_sel_o = 1'b1;
                end
            end
            5'b011??, 5'b1000?: begin
                cls_o         = CLS_SINGLE;
                src_b_o       = SRC_B_IMM;
                wb_from_mem_o = 1'b1;
                if (instr_i[11]) begin
                    mem_read_o  = 1'b1;
                    reg_write_o = 1'b1;
                end else begin
                    mem_write_o = 1'b1;
                end
            end
            5'b1011?: begin
                // bit 8 is ignored, so neither LR nor PC joins the list
                if (instr_i[7:0] != '0) begin
                    if (instr_i[15:9] == 7'b1011010) begin
                        cls_o = CLS_PUSH;
                    end else if (instr_i[15:9] == 7'b1011110) begin
                        cls_o = CLS_POP;
                    end
                end
            end
            5'b11000: begin
                if (instr_i[7:0] != '0) begin
                    cls_o = CLS_STM;
                end
            end
            5'b11001: begin
                if (instr_i[7:0] != '0) begin
                    cls_o = CLS_LDM;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- thumb_ctrl_pkg.sv
`include "thumb_ctrl_params.svh"

package thumb_ctrl_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`INSTR_W-1:0]    instr_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // bit i of a list stands for register ri
    typedef logic [`REG_LIST_W-1:0] reg_list_t;
    typedef logic [`BEAT_W-1:0]     beat_t;

    typedef enum logic [2:0] {
        CLS_SINGLE,
        CLS_PUSH,
        CLS_POP,
        CLS_STM,
        CLS_LDM,
        CLS_INVALID
    } instr_class_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        LSL,
        LSR,
        ASR,
        ROR,
        ADC,
        SBC,
        MUL,
        BIC,
        NOT
    } alu_op_e;

    typedef enum logic {
        SRC_A_REG,
        SRC_A_ZERO
    } src_a_e;

    // SRC_B_OFFSET picks the offset immediate made by the control unit
    typedef enum logic [1:0] {
        SRC_B_REG,
        SRC_B_IMM,
        SRC_B_ZERO,
        SRC_B_OFFSET
    } src_b_e;

    typedef enum logic {
        ADDR_FROM_INSTR,
        ADDR_FROM_CTRL
    } addr_sel_e;

endpackage

//--- thumb_ctrl_params.svh
`ifndef THUMB_CTRL_PARAMS_SVH
`define THUMB_CTRL_PARAMS_SVH

// datapath and instruction widths
`define WORD_W      32
`define INSTR_W     16
`define REG_ADDR_W  4

// only r0 to r7 can appear in a register list
`define REG_LIST_W  8
`define BEAT_W      4

// stack pointer register number
`define SP_REG_NUM  13

`endif
